/* verilog/idu_defines.svh */
/*
 * Sizing macros for the increment/decrement unit
 * Counter half width and register pair count
 */
`ifndef IDU_DEFINES_SVH
`define IDU_DEFINES_SVH

// One counter half, low or high byte of a pair
`define IDU_HALF_W 8

// BC, DE, HL, SP and PC
`define IDU_NUM_PAIRS 5

`endif

/* verilog/idu_pkg.sv */
/*
 * Shared types of the increment/decrement unit
 * Operation and pair-select encodings
 * Register pair, command and external load structs
 */
`default_nettype none

`include "idu_defines.svh"

package idu_pkg;

	// Count operation carried with a command
	typedef enum logic [2:0] {
		OP_NONE     = 3'd0, // Value passes unchanged
		OP_INC      = 3'd1, // 16-bit increment
		OP_DEC      = 3'd2, // 16-bit decrement
		OP_PAIR_INC = 3'd3, // Both bytes +1, no carry between them
		OP_PAIR_DEC = 3'd4  // Both bytes -1, no borrow between them
	} idu_op_t;

	// Register pair select
	typedef enum logic [2:0] {
		SEL_BC = 3'd0,
		SEL_DE = 3'd1,
		SEL_HL = 3'd2,
		SEL_SP = 3'd3,
		SEL_PC = 3'd4
	} pair_sel_t;

	// One register pair, high byte in the upper bits
	typedef struct packed {
		logic [`IDU_HALF_W-1:0] hi;
		logic [`IDU_HALF_W-1:0] lo;
	} reg_pair_t;

	// Count command from the sequencer
	typedef struct packed {
		logic      strobe; // Single-cycle valid
		idu_op_t   op;
		pair_sel_t sel;
		logic      wb;     // Write result back into the pair
	} idu_cmd_t;

	// External register load
	typedef struct packed {
		logic      strobe;
		pair_sel_t sel;
		reg_pair_t data;
	} reg_load_t;

endpackage

`default_nettype wire

/* verilog/idu_carry_chain.sv */
/*
 * Carry-lookahead chain of the 16-bit count unit
 * Two byte halves, pairwise carry break, enable gating
 */
`timescale 1ns/1ns
`default_nettype none

`include "idu_defines.svh"

module idu_carry_chain (
	input  logic                      en,       // Count strobe, gates all carries
	input  logic                      pairwise, // Force a fresh carry into the high half
	input  logic [2*`IDU_HALF_W-1:0] mq,       // Per-bit propagate terms
	output logic [2*`IDU_HALF_W-1:0] xa        // Per-bit carry in
);

	localparam int HW = `IDU_HALF_W;
	localparam int W  = 2 * HW;

	logic [W-1:0] nxa; // Active-low carries, as built in silicon
	logic         ct;  // Carry into the high half

	genvar i;

	// Bit 0 always receives the count when enabled
	assign nxa[0] = ~en;

	// Low half, each carry is the AND of all lower propagate terms
	generate
		for (i = 1; i < HW; i++) begin : g_lo
			assign nxa[i] = en ? ~(&mq[i-1:0]) : 1'b1;
		end
	endgenerate

	// Low half carry-out, or forced one for pairwise counting
	assign ct = (mq[HW-1] & xa[HW-1]) | pairwise;

	// High half starts from ct
	assign nxa[HW] = en ? ~ct : 1'b1;

	generate
		for (i = 1; i < HW; i++) begin : g_hi
			// AND of ct and the propagate terms inside the high half
			assign nxa[HW+i] = en ? ~(ct & (&mq[HW+i-1:HW])) : 1'b1;
		end
	endgenerate

	assign xa = ~nxa; // Back to active high

endmodule

`default_nettype wire

/* verilog/idu_core.sv */
/*
 * Count core of the increment/decrement unit
 * Operation decode, per-bit count slices, carry chain instance
 */
`timescale 1ns/1ns
`default_nettype none

`include "idu_defines.svh"

module idu_core import idu_pkg::*; (
	input  reg_pair_t operand, // Keeper value
	input  idu_op_t   op,      // Registered operation
	output reg_pair_t result   // Counted value, combinational
);

	localparam int W = 2 * `IDU_HALF_W;

	logic         en;       // Any count requested
	logic         pairwise; // Halves count on their own
	logic         dir_dec;  // Count down
	logic [W-1:0] val;      // Flat operand
	logic [W-1:0] mq;       // Propagate terms from the slices
	logic [W-1:0] xa;       // Carry in to the slices
	logic [W-1:0] sum;      // Slice outputs

	// Decode the operation into chain controls
	always_comb begin
		en       = 1'b0;
		pairwise = 1'b0;
		dir_dec  = 1'b0;
		case (op)
			OP_INC: begin
				en = 1'b1;
			end
			OP_DEC: begin
				en      = 1'b1;
				dir_dec = 1'b1;
			end
			OP_PAIR_INC: begin
				en       = 1'b1;
				pairwise = 1'b1;
			end
			OP_PAIR_DEC: begin
				en       = 1'b1;
				pairwise = 1'b1;
				dir_dec  = 1'b1;
			end
			default: ; // OP_NONE and unused codes pass through
		endcase
	end

	assign val = operand;

	// Count slices
	genvar i;
	generate
		for (i = 0; i < W; i++) begin : g_slice
			// A one propagates an increment, a zero propagates a borrow
			assign mq[i]  = dir_dec ? ~val[i] : val[i];
			assign sum[i] = val[i] ^ xa[i]; // Toggle on carry in
		end
	endgenerate

	idu_carry_chain i_carry_chain (
		.en       (en),
		.pairwise (pairwise),
		.mq       (mq),
		.xa       (xa)
	);

	assign result = sum;

endmodule

`default_nettype wire

/* verilog/reg_pair_file.sv */
/*
 * Register pairs BC, DE, HL, SP, PC with the operand keeper
 * Command capture with forwarding, write-back, external load
 * Combinational read port and address output
 */
`timescale 1ns/1ns
`default_nettype none

`include "idu_defines.svh"

module reg_pair_file import idu_pkg::*; (
	input  logic      clk4,
	input  logic      reset,
	input  idu_cmd_t  cmd,     // Count command
	input  reg_load_t ld,      // External load
	input  pair_sel_t rd_sel,  // Read port select
	input  reg_pair_t result,  // From the count core
	output reg_pair_t operand, // Keeper to the count core
	output idu_op_t   op_q,    // Operation of the live command
	output reg_pair_t rd_data,
	output reg_pair_t addr,
	output logic      addr_en
);

	reg_pair_t pairs [`IDU_NUM_PAIRS]; // Indexed by pair_sel_t
	reg_pair_t keeper;                 // Operand keeper
	pair_sel_t sel_q;                  // Pair of the live command
	logic      wb_q;                   // Live command writes back
	logic      wb_fire;                // Write-back at this edge
	logic      ld_fire;                // Load at this edge
	logic      ld_blocked;             // Load loses to write-back
	reg_pair_t cap_val;                // Next keeper value

	// Select codes 5..7 name no pair
	function automatic logic sel_ok(input pair_sel_t sel);
		return int'(sel) < `IDU_NUM_PAIRS;
	endfunction

	assign wb_fire    = wb_q & sel_ok(sel_q);
	assign ld_fire    = ld.strobe & sel_ok(ld.sel);
	assign ld_blocked = wb_fire & (ld.sel == sel_q); // Same pair, write-back wins

	// Keeper source, newest value of the selected pair
	always_comb begin
		cap_val = '0;
		if (sel_ok(cmd.sel)) begin
			if (wb_fire && (sel_q == cmd.sel)) begin
				cap_val = result;           // Forward the write-back
			end else if (ld_fire && (ld.sel == cmd.sel)) begin
				cap_val = ld.data;          // Forward the load
			end else begin
				cap_val = pairs[cmd.sel];
			end
		end
	end

	// Pair storage
	always_ff @(posedge clk4) begin
		if (reset) begin
			for (int i = 0; i < `IDU_NUM_PAIRS; i++) begin
				pairs[i] <= '0;
			end
		end else begin
			if (ld_fire && !ld_blocked) begin
				pairs[ld.sel] <= ld.data;
			end
			if (wb_fire) begin
				pairs[sel_q] <= result; // One cycle after capture
			end
		end
	end

	// Keeper and command state
	always_ff @(posedge clk4) begin
		if (reset) begin
			keeper  <= '0;
			op_q    <= OP_NONE;
			sel_q   <= SEL_BC;
			wb_q    <= 1'b0;
			addr_en <= 1'b0;
		end else begin
			addr_en <= cmd.strobe;          // Live for one cycle
			wb_q    <= cmd.strobe & cmd.wb;
			if (cmd.strobe) begin
				keeper <= cap_val;
				op_q   <= cmd.op;
				sel_q  <= cmd.sel;
			end
		end
	end

	// Read port
	always_comb begin
		rd_data = '0;
		if (sel_ok(rd_sel)) begin
			rd_data = pairs[rd_sel];
		end
	end

	assign operand = keeper;
	assign addr    = keeper; // Address bus shows the uncounted value

endmodule

`default_nettype wire

/* verilog/idu_top.sv */
/*
 * Top level of the increment/decrement unit
 * Register pair file and count core
 */
`timescale 1ns/1ns
`default_nettype none

module idu_top import idu_pkg::*; (
	input  logic      clk4,
	input  logic      reset,
	input  idu_cmd_t  cmd,     // Count command
	input  reg_load_t ld,      // External register load
	input  pair_sel_t rd_sel,  // Read port select
	output reg_pair_t rd_data, // Read port data
	output reg_pair_t addr,    // Address bus
	output logic      addr_en  // Address bus valid
);

	reg_pair_t operand; // Keeper value
	idu_op_t   op_q;    // Registered operation
	reg_pair_t result;  // Counted value

	// Pairs, keeper and write-back
	reg_pair_file i_reg_pair_file (
		.clk4    (clk4),
		.reset   (reset),
		.cmd     (cmd),
		.ld      (ld),
		.rd_sel  (rd_sel),
		.result  (result),
		.operand (operand),
		.op_q    (op_q),
		.rd_data (rd_data),
		.addr    (addr),
		.addr_en (addr_en)
	);

	// Increment and decrement
	idu_core i_idu_core (
		.operand (operand),
		.op      (op_q),
		.result  (result)
	);

endmodule

`default_nettype wire

/* verif/idu_checker.sv */
/*
 * Reference model and checker of the increment/decrement unit
 * Five-pair model with forwarding, per-test result lines
 */
`timescale 1ns/1ns
`default_nettype none

`include "idu_defines.svh"

module idu_checker import idu_pkg::*; (
	input  logic      clk4,
	input  logic      reset,
	input  idu_cmd_t  cmd,
	input  reg_load_t ld,
	input  pair_sel_t rd_sel,
	input  reg_pair_t rd_data,
	input  reg_pair_t addr,
	input  logic      addr_en,
	input  int        test_id,      // 0 between tests
	output int        tests_run,
	output int        tests_failed,
	output int        errors        // All mismatches
);

	reg_pair_t model [`IDU_NUM_PAIRS];
	reg_pair_t keep_m; // Expected keeper
	idu_op_t   op_m;
	pair_sel_t sel_m;
	logic      wb_m;   // Write-back due at next edge
	logic      en_m;   // Expected addr_en
	int        cur_id;
	int        test_errs;

	initial begin
		tests_run    = 0;
		tests_failed = 0;
		errors       = 0;
		cur_id       = 0;
		test_errs    = 0;
	end

	function automatic string test_name(input int id);
		case (id)
			1: return "load_read";
			2: return "count16";
			3: return "pair_count";
			4: return "addr_out";
			5: return "back_to_back";
			default: return "idle";
		endcase
	endfunction

	// Count rule with the bytes of pairwise ops kept apart
	function automatic reg_pair_t count_ref(input reg_pair_t v, input idu_op_t op);
		reg_pair_t r;
		r = v;
		case (op)
			OP_INC: r = v + 16'd1;
			OP_DEC: r = v - 16'd1; // Wraps 0000 to ffff
			OP_PAIR_INC: begin
				r.hi = v.hi + 8'd1;
				r.lo = v.lo + 8'd1;
			end
			OP_PAIR_DEC: begin
				r.hi = v.hi - 8'd1;
				r.lo = v.lo - 8'd1;
			end
			default: r = v;
		endcase
		return r;
	endfunction

	task automatic check_val(input string what, input logic [15:0] exp,
		input logic [15:0] act);
		if (act !== exp) begin
			$display("[FAIL] %s %s: expected %h, actual %h", test_name(cur_id), what,
				exp, act);
			errors++;
			test_errs++;
		end
	endtask

	// Model step on the inputs sampled at this edge
	always @(posedge clk4) begin : model_step
		reg_pair_t res;
		reg_pair_t cap;
		if (reset) begin
			foreach (model[i])
				model[i] = '0;
			keep_m = '0;
			op_m   = OP_NONE;
			sel_m  = SEL_BC;
			wb_m   = 1'b0;
			en_m   = 1'b0;
		end else begin
			res = count_ref(keep_m, op_m);
			cap = model[cmd.sel];
			if (ld.strobe && ld.sel == cmd.sel)
				cap = ld.data;          // Loaded data seen by the capture
			if (wb_m && sel_m == cmd.sel)
				cap = res;              // Forwarded write-back is newest
			if (ld.strobe)
				model[ld.sel] = ld.data;
			if (wb_m)
				model[sel_m] = res;     // Write-back wins a collision
			en_m = cmd.strobe;
			wb_m = cmd.strobe & cmd.wb;
			if (cmd.strobe) begin
				keep_m = cap;
				op_m   = cmd.op;
				sel_m  = cmd.sel;
			end
		end
	end

	// Outputs are settled at the falling edge
	always @(negedge clk4) begin
		if (!reset) begin
			check_val("addr_en", 16'(en_m), 16'(addr_en));
			if (en_m)
				check_val("addr", keep_m, addr);
			check_val("rd_data", model[rd_sel], rd_data);
		end
	end

	// One line per test when its id changes
	always @(posedge clk4) begin
		if (test_id != cur_id) begin
			if (cur_id != 0) begin
				tests_run++;
				if (test_errs == 0) begin
					$display("[PASS] %s", test_name(cur_id));
				end else begin
					tests_failed++;
					$display("[FAIL] %s mismatches: expected 0, actual %0d",
						test_name(cur_id), test_errs);
				end
			end
			cur_id    = test_id;
			test_errs = 0;
		end
	end

endmodule

`default_nettype wire

/* verif/idu_sva.sv */
/*
 * Concurrent assertions on the address bus of idu_top
 * Bind of the assertion module into idu_top
 */
`timescale 1ns/1ns
`default_nettype none

module idu_sva import idu_pkg::*; (
	input logic      clk4,
	input logic      reset,
	input idu_cmd_t  cmd,
	input reg_pair_t addr,
	input logic      addr_en
);

	// Bus idle after any reset edge
	a_reset_idle: assert property (@(posedge clk4) reset |=> !addr_en)
		else $error("addr_en high in the cycle after a reset edge");

	a_en_follows: assert property (@(posedge clk4) disable iff (reset)
		1'b1 |=> (addr_en == $past(cmd.strobe))) // One-cycle delay
		else $error("addr_en does not follow the command strobe by one cycle");

	// Keeper holds while no new command arrives
	a_addr_hold: assert property (@(posedge clk4) disable iff (reset)
		(addr_en && !cmd.strobe) |=> $stable(addr))
		else $error("addr changed without a new command");

endmodule

bind idu_top idu_sva i_idu_sva (.clk4, .reset, .cmd, .addr, .addr_en);

`default_nettype wire

/* verif/idu_tb.sv */
/*
 * Testbench of the increment/decrement unit
 * Clock, reset, LFSR stimulus, DUT and checker instances, summary
 */
`timescale 1ns/1ns
`default_nettype none

module idu_tb import idu_pkg::*; ();

	localparam int NUM_TESTS  = 5;
	localparam int WAIT_LIMIT = 50; // Cycles per wait loop

	logic        clk4 = 1'b0;
	logic        reset;
	idu_cmd_t    cmd;
	reg_load_t   ld;
	pair_sel_t   rd_sel;
	reg_pair_t   rd_data;
	reg_pair_t   addr;
	logic        addr_en;
	int          test_id;
	int          tests_run;
	int          tests_failed;
	int          errors;
	logic        timed_out;           // A wait loop ran out
	logic [31:0] lfsr = 32'h2cb0d119; // Stimulus seed

	always #10 clk4 = ~clk4; // 20 ns period

	idu_top i_idu_top (.clk4, .reset, .cmd, .ld, .rd_sel, .rd_data, .addr, .addr_en);

	idu_checker i_checker (.clk4, .reset, .cmd, .ld, .rd_sel, .rd_data, .addr, .addr_en,
		.test_id, .tests_run, .tests_failed, .errors);

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int k = 0; k < n; k++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]; // One step per bit
			lfsr = {lfsr[30:0], fb};
			r    = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic pair_sel_t rand_sel();
		return pair_sel_t'(3'(rand_bits(8) % 5));
	endfunction

	function automatic idu_op_t rand_op();
		return idu_op_t'(3'(rand_bits(8) % 5));
	endfunction

	// One clock of stimulus
	task automatic drive(input idu_cmd_t c, input reg_load_t l, input pair_sel_t r);
		@(posedge clk4);
		cmd    <= c;
		ld     <= l;
		rd_sel <= r;
	endtask

	task automatic start_test(input int id);
		@(posedge clk4);
		test_id <= id;
		cmd     <= '0;
		ld      <= '0;
	endtask

	task automatic load_pair(input pair_sel_t sel, input logic [15:0] data);
		drive('0, {1'b1, sel, data}, sel);
		drive('0, '0, sel); // Read back
	endtask

	// Command then idle until addr_en shows it and the write-back lands
	task automatic run_cmd(input idu_op_t op, input pair_sel_t sel, input logic wb);
		int n;
		drive({1'b1, op, sel, wb}, '0, sel);
		drive('0, '0, sel);
		n = 0;
		do begin
			@(negedge clk4);
			n++;
		end while (!addr_en && n < WAIT_LIMIT);
		if (!addr_en) begin
			$display("addr_en never rose after a command");
			timed_out = 1'b1;
		end
		drive('0, '0, sel);
	endtask

	initial begin
		int        n;
		pair_sel_t sel;
		reset     = 1'b1;
		cmd       = '0;
		ld        = '0;
		rd_sel    = SEL_BC;
		test_id   = 0;
		timed_out = 1'b0;
		repeat (3) @(posedge clk4);
		reset <= 1'b0;

		start_test(1); // Zeros after reset then random loads
		for (int s = 0; s < 5; s++)
			drive('0, '0, pair_sel_t'(3'(s)));
		repeat (20) load_pair(rand_sel(), 16'(rand_bits(16)));

		start_test(2); // Carry and both wraps
		load_pair(SEL_HL, 16'hffff);
		run_cmd(OP_INC, SEL_HL, 1'b1);
		run_cmd(OP_DEC, SEL_HL, 1'b1);
		load_pair(SEL_BC, 16'h00ff);
		run_cmd(OP_INC, SEL_BC, 1'b1);
		load_pair(SEL_BC, 16'hff00);
		run_cmd(OP_INC, SEL_BC, 1'b1);
		repeat (20) begin
			sel = rand_sel();
			load_pair(sel, 16'(rand_bits(16)));
			run_cmd(rand_bits(1) ? OP_DEC : OP_INC, sel, 1'b1);
		end

		start_test(3); // Bytes count apart
		load_pair(SEL_DE, 16'h00ff);
		run_cmd(OP_PAIR_INC, SEL_DE, 1'b1);
		load_pair(SEL_DE, 16'hff00);
		run_cmd(OP_PAIR_INC, SEL_DE, 1'b1);
		load_pair(SEL_SP, 16'h0000);
		run_cmd(OP_PAIR_DEC, SEL_SP, 1'b1);
		repeat (20) begin
			sel = rand_sel();
			load_pair(sel, 16'(rand_bits(16)));
			run_cmd(rand_bits(1) ? OP_PAIR_DEC : OP_PAIR_INC, sel, 1'b1);
		end

		start_test(4); // Any op with random wb
		repeat (30) run_cmd(rand_op(), rand_sel(), 1'(rand_bits(1)));

		start_test(5); // Pipelined with HL favored so forwarding and collisions occur
		repeat (200) begin
			sel = rand_bits(1) ? SEL_HL : rand_sel();
			drive({(rand_bits(2) != 0), rand_op(), sel, 1'(rand_bits(1))},
				{(rand_bits(2) == 0), rand_bits(1) ? sel : rand_sel(), 16'(rand_bits(16))},
				rand_sel());
		end
		repeat (2) drive('0, '0, SEL_HL); // Drain the last write-back

		start_test(0);
		n = 0;
		while (tests_run < NUM_TESTS && n < WAIT_LIMIT) begin
			@(negedge clk4);
			n++;
		end
		if (tests_run < NUM_TESTS)
			$display("Checker did not close every test");
		$display("Tests: %0d run, %0d failed, %0d mismatches", tests_run, tests_failed,
			errors);
		if (!timed_out && tests_run == NUM_TESTS && tests_failed == 0 && errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
+incdir+verilog
verilog/idu_pkg.sv
verilog/idu_carry_chain.sv
verilog/idu_core.sv
verilog/reg_pair_file.sv
verilog/idu_top.sv
verif/idu_checker.sv
verif/idu_sva.sv
verif/idu_tb.sv

/* Makefile */
SIM   = verilator
FLAGS = --binary --timing --assert
TOP   = idu_tb
FLIST = flist.f

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
